// ==== design/clic_pkg.sv ====
// sizes fixed for 8 sources and 8 priority levels; changing VecSize needs free CSR addresses
package clic_pkg;

  // data and address sizes
  typedef logic [31:0] word;
  typedef logic [4:0] reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  localparam int IMemAddrWidth = 16;
  typedef logic [IMemAddrWidth-1:0] i_mem_addr_t;
  // word address, byte offset dropped
  typedef logic [IMemAddrWidth-3:0] vec_store_t;

  // priority and nesting
  localparam int PrioWidth = 3;
  typedef logic [PrioWidth-1:0] prio_t;
  localparam int PrioLevels = 8;
  typedef logic [3:0] level_t;

  localparam int VecSize = 8;

  // csr map
  localparam csr_addr_t MIntThreshAddr = 12'h347;
  localparam csr_addr_t VecCsrBase = 12'hB00;
  localparam csr_addr_t EntryCsrBase = 12'hB20;

  // all ones pc marks return from interrupt
  localparam i_mem_addr_t RetMarker = '1;

  // fits in a 5 bit immediate
  typedef struct packed {
    prio_t prio;
    logic  enabled;
    logic  pended;
  } entry_t;

  typedef struct packed {
    i_mem_addr_t addr;
    prio_t       prio;
  } stack_entry_t;

  // funct3 encoding of the zicsr instructions
  typedef enum logic [2:0] {
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } csr_op_t;

  typedef enum logic {
    PC_NORMAL,
    PC_INTERRUPT
  } pc_interrupt_mux_t;

  // new csr contents for a given access
  function automatic word csr_apply(word old_val, csr_op_t op, word rs1_data,
                                    reg_idx_t rs1_zimm);
    word zimm_ext;
    word result;
    zimm_ext = word'(rs1_zimm);
    case (op)
      CSRRW:   result = rs1_data;
      CSRRS:   result = old_val | rs1_data;
      CSRRC:   result = old_val & ~rs1_data;
      CSRRWI:  result = zimm_ext;
      CSRRSI:  result = old_val | zimm_ext;
      CSRRCI:  result = old_val & ~zimm_ext;
      default: result = old_val;
    endcase
    return result;
  endfunction

endpackage

// ==== design/csr_bus_if.sv ====
// single cycle strobe bus without acknowledge; addr and op are only valid while csr_enable is high
`timescale 1ns/1ps

interface csr_bus_if import clic_pkg::*; ();

  logic      csr_enable;
  csr_addr_t csr_addr;
  reg_idx_t  rs1_zimm;
  word       rs1_data;
  csr_op_t   csr_op;

  // driven from the top level ports
  modport master(
    output csr_enable, csr_addr, rs1_zimm, rs1_data, csr_op
  );

  // every register and the read mux listen
  modport slave(
    input csr_enable, csr_addr, rs1_zimm, rs1_data, csr_op
  );

endinterface

// ==== design/csr_reg.sv ====
// Width must not exceed 32; upper bits of a write are dropped and reads are zero-extended
`timescale 1ns/1ps

module csr_reg import clic_pkg::*; #(
  parameter csr_addr_t Addr  = 12'h000,
  parameter int        Width = 32
) (
  input  logic      clk,
  input  logic      reset,
  csr_bus_if.slave  bus,
  output word       value
);

  logic [Width-1:0] data;
  logic             hit;
  word              next_value;

  // address decode for this register only
  assign hit = bus.csr_enable && (bus.csr_addr == Addr);

  // full word result, truncated on store
  assign next_value = csr_apply(word'(data), bus.csr_op, bus.rs1_data, bus.rs1_zimm);

  always_ff @(posedge clk) begin
    if (reset) begin
      data <= '0;
    end else if (hit) begin
      data <= next_value[Width-1:0];
    end
  end

  assign value = word'(data);

endmodule

// ==== design/epc_stack.sv ====
// holds at most PrioLevels entries; data_out is undefined while the stack is empty
`timescale 1ns/1ps

module epc_stack import clic_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         push,
  input  logic         pop,
  input  stack_entry_t data_in,
  output stack_entry_t data_out,
  output level_t       level_out
);

  stack_entry_t mem [PrioLevels];
  level_t       count;
  logic [2:0]   wr_idx;
  logic [2:0]   top_idx;

  // next free slot and current top
  assign wr_idx  = count[2:0];
  assign top_idx = wr_idx - 3'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (push) begin
      count <= count + level_t'(1);
    end else if (pop) begin
      count <= count - level_t'(1);
    end
  end

  // saved pc and threshold pairs
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_idx] <= data_in;
    end
  end

  assign data_out  = mem[top_idx];
  assign level_out = count;

  // overflow would wrap the write index onto the bottom entry
  a_no_overflow : assert property (@(posedge clk) disable iff (reset)
    push |-> count != level_t'(PrioLevels));

  a_no_underflow : assert property (@(posedge clk) disable iff (reset)
    pop |-> count != '0);

  // the decision logic picks exactly one action per cycle
  a_push_pop_exclusive : assert property (@(posedge clk) disable iff (reset)
    !(push && pop));

endmodule

// ==== design/prio_select.sv ====
// purely combinational; ties between equal priorities go to the highest source index
`timescale 1ns/1ps

module prio_select import clic_pkg::*; (
  input  entry_t     entries [VecSize],
  input  vec_store_t vectors [VecSize],
  input  prio_t      thresh,
  output logic       found,
  output prio_t      best_prio,
  output vec_store_t best_vec
);

  always_comb begin
    logic       any;
    prio_t      max_prio;
    vec_store_t max_vec;
    logic       eligible;

    any      = 1'b0;
    max_prio = '0;
    max_vec  = '0;

    // ordered scan, later sources win on equal prio
    for (int k = 0; k < VecSize; k++) begin
      eligible = entries[k].enabled && entries[k].pended && (entries[k].prio > thresh);
      if (eligible && (!any || entries[k].prio >= max_prio)) begin
        any      = 1'b1;
        max_prio = entries[k].prio;
        max_vec  = vectors[k];
      end
    end

    found     = any;
    best_prio = max_prio;
    best_vec  = max_vec;
  end

endmodule

// ==== design/n_clic.sv ====
// pended bits are software only; a RetMarker pc with an empty stack and no pending source is illegal
`timescale 1ns/1ps

module n_clic import clic_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  csr_bus_if.slave          bus,
  input  i_mem_addr_t       pc_in,
  output word               csr_out,
  output i_mem_addr_t       int_addr,
  output pc_interrupt_mux_t pc_interrupt_sel,
  output level_t            level_out,
  output logic              interrupt_out
);

  word          vec_word   [VecSize];
  word          entry_word [VecSize];
  entry_t       entries    [VecSize];
  vec_store_t   vectors    [VecSize];

  prio_t        thresh;
  prio_t        thresh_csr_next;
  word          thresh_apply;
  logic         thresh_csr_hit;
  logic         thresh_update;
  prio_t        thresh_new;

  logic         found;
  prio_t        best_prio;
  vec_store_t   best_vec;
  logic         is_ret;

  logic         push;
  logic         pop;
  stack_entry_t stack_in;
  stack_entry_t stack_out;

  // one vector and one entry register per source
  for (genvar k = 0; k < VecSize; k++) begin : gen_src
    csr_reg #(
      .Addr  (csr_addr_t'(VecCsrBase + k)),
      .Width ($bits(vec_store_t))
    ) vec_reg (
      .clk   (clk),
      .reset (reset),
      .bus   (bus),
      .value (vec_word[k])
    );

    csr_reg #(
      .Addr  (csr_addr_t'(EntryCsrBase + k)),
      .Width ($bits(entry_t))
    ) entry_reg (
      .clk   (clk),
      .reset (reset),
      .bus   (bus),
      .value (entry_word[k])
    );

    assign entries[k] = entry_t'(entry_word[k][$bits(entry_t)-1:0]);
    assign vectors[k] = vec_word[k][$bits(vec_store_t)-1:0];
  end

  // threshold register where a decision update beats a csr write
  assign thresh_csr_hit  = bus.csr_enable && (bus.csr_addr == MIntThreshAddr);
  assign thresh_apply    = csr_apply(word'(thresh), bus.csr_op, bus.rs1_data, bus.rs1_zimm);
  assign thresh_csr_next = thresh_apply[PrioWidth-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      thresh <= '0;
    end else if (thresh_update) begin
      thresh <= thresh_new;
    end else if (thresh_csr_hit) begin
      thresh <= thresh_csr_next;
    end
  end

  prio_select prio_select_i (
    .entries   (entries),
    .vectors   (vectors),
    .thresh    (thresh),
    .found     (found),
    .best_prio (best_prio),
    .best_vec  (best_vec)
  );

  assign stack_in = '{addr: pc_in, prio: thresh};

  epc_stack epc_stack_i (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .pop       (pop),
    .data_in   (stack_in),
    .data_out  (stack_out),
    .level_out (level_out)
  );

  assign is_ret = (pc_in == RetMarker);

  // take, tail chain, return or pass through
  always_comb begin
    push             = 1'b0;
    pop              = 1'b0;
    thresh_update    = 1'b0;
    thresh_new       = '0;
    int_addr         = pc_in;
    interrupt_out    = 1'b0;
    pc_interrupt_sel = PC_NORMAL;
    if (found) begin
      // tail chain when returning, otherwise a fresh take
      push             = !is_ret;
      thresh_update    = 1'b1;
      thresh_new       = best_prio;
      int_addr         = {best_vec, 2'b00};
      interrupt_out    = 1'b1;
      pc_interrupt_sel = PC_INTERRUPT;
    end else if (is_ret) begin
      pop              = 1'b1;
      thresh_update    = 1'b1;
      thresh_new       = stack_out.prio;
      int_addr         = stack_out.addr;
      pc_interrupt_sel = PC_INTERRUPT;
    end
  end

  // read mux with zero for unmapped addresses
  always_comb begin
    csr_out = '0;
    if (bus.csr_addr == MIntThreshAddr) begin
      csr_out = word'(thresh);
    end
    for (int k = 0; k < VecSize; k++) begin
      if (bus.csr_addr == csr_addr_t'(VecCsrBase + k)) begin
        csr_out = vec_word[k];
      end
      if (bus.csr_addr == csr_addr_t'(EntryCsrBase + k)) begin
        csr_out = entry_word[k];
      end
    end
  end

  a_int_redirects : assert property (@(posedge clk) disable iff (reset)
    interrupt_out |-> pc_interrupt_sel == PC_INTERRUPT);

endmodule

// ==== design/clic_top.sv ====
// core must present RetMarker on pc_in for one cycle per return; no back-pressure exists
`timescale 1ns/1ps

module clic_top import clic_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              csr_enable,
  input  csr_addr_t         csr_addr,
  input  reg_idx_t          rs1_zimm,
  input  word               rs1_data,
  input  csr_op_t           csr_op,
  input  i_mem_addr_t       pc_in,
  output word               csr_out,
  output i_mem_addr_t       int_addr,
  output pc_interrupt_mux_t pc_interrupt_sel,
  output level_t            level_out,
  output logic              interrupt_out
);

  csr_bus_if bus ();

  // csr access ports onto the bus
  assign bus.csr_enable = csr_enable;
  assign bus.csr_addr   = csr_addr;
  assign bus.rs1_zimm   = rs1_zimm;
  assign bus.rs1_data   = rs1_data;
  assign bus.csr_op     = csr_op;

  n_clic n_clic_i (
    .clk              (clk),
    .reset            (reset),
    .bus              (bus.slave),
    .pc_in            (pc_in),
    .csr_out          (csr_out),
    .int_addr         (int_addr),
    .pc_interrupt_sel (pc_interrupt_sel),
    .level_out        (level_out),
    .interrupt_out    (interrupt_out)
  );

endmodule

// ==== tb/clic_model.svh ====
// untimed clic model for inclusion inside clic_tb; RetMarker with an empty stack and no winner is not modelled
`ifndef CLIC_MODEL_SVH
`define CLIC_MODEL_SVH

  vec_store_t        m_vec        [VecSize];
  entry_t            m_entry      [VecSize];
  prio_t             m_thresh;
  i_mem_addr_t       m_stack_addr [PrioLevels];
  prio_t             m_stack_prio [PrioLevels];
  int                m_level;

  // winner and expected outputs of the current cycle
  logic              m_found;
  prio_t             m_best_prio;
  vec_store_t        m_best_vec;
  word               m_exp_csr;
  i_mem_addr_t       m_exp_addr;
  pc_interrupt_mux_t m_exp_sel;
  logic              m_exp_int;
  level_t            m_exp_level;

  function automatic void model_reset();
    for (int k = 0; k < VecSize; k++) begin
      m_vec[k]   = '0;
      m_entry[k] = '0;
    end
    m_thresh = '0;
    m_level  = 0;
  endfunction

  // write, set or clear with register or immediate operand
  function automatic word csr_update(word old_val, csr_op_t op, word data, reg_idx_t zimm);
    word operand;
    operand = (op inside {CSRRWI, CSRRSI, CSRRCI}) ? {27'b0, zimm} : data;
    if (op == CSRRW || op == CSRRWI) begin
      return operand;
    end
    if (op == CSRRS || op == CSRRSI) begin
      return old_val | operand;
    end
    return old_val & ~operand;
  endfunction

  function automatic word model_read(csr_addr_t addr);
    word val;
    val = '0;
    if (addr == MIntThreshAddr) begin
      val = {29'b0, m_thresh};
    end
    for (int k = 0; k < VecSize; k++) begin
      if (addr == VecCsrBase + k) begin
        val = {18'b0, m_vec[k]};
      end
      if (addr == EntryCsrBase + k) begin
        val = {27'b0, m_entry[k]};
      end
    end
    return val;
  endfunction

  // scan from the top index down so a tie keeps the higher source
  function automatic void model_find_best();
    m_found     = 1'b0;
    m_best_prio = '0;
    m_best_vec  = '0;
    for (int k = VecSize - 1; k >= 0; k--) begin
      if (m_entry[k].enabled && m_entry[k].pended && (m_entry[k].prio > m_thresh) &&
          (!m_found || m_entry[k].prio > m_best_prio)) begin
        m_found     = 1'b1;
        m_best_prio = m_entry[k].prio;
        m_best_vec  = m_vec[k];
      end
    end
  endfunction

  function automatic void model_predict(csr_addr_t addr, i_mem_addr_t pc);
    model_find_best();
    m_exp_csr   = model_read(addr);
    m_exp_level = level_t'(m_level);
    m_exp_int   = 1'b0;
    m_exp_sel   = PC_NORMAL;
    m_exp_addr  = pc;
    if (m_found) begin
      m_exp_int  = 1'b1;
      m_exp_sel  = PC_INTERRUPT;
      m_exp_addr = {m_best_vec, 2'b00};
    end else if (pc == RetMarker) begin
      m_exp_sel  = PC_INTERRUPT;
      m_exp_addr = m_stack_addr[m_level-1];
    end
  endfunction

  // state after the next rising edge
  function automatic void model_advance(logic en, csr_addr_t addr, csr_op_t op, word data,
                                        reg_idx_t zimm, i_mem_addr_t pc);
    logic  decided;
    prio_t next_thresh;
    word   wval;
    decided     = 1'b0;
    next_thresh = m_thresh;
    if (m_found) begin
      if (pc != RetMarker) begin
        m_stack_addr[m_level] = pc;
        m_stack_prio[m_level] = m_thresh;
        m_level++;
      end
      decided     = 1'b1;
      next_thresh = m_best_prio;
    end else if (pc == RetMarker) begin
      m_level--;
      decided     = 1'b1;
      next_thresh = m_stack_prio[m_level];
    end
    if (en) begin
      wval = csr_update(model_read(addr), op, data, zimm);
      // the interrupt decision beats a software threshold write
      if (addr == MIntThreshAddr && !decided) begin
        next_thresh = wval[PrioWidth-1:0];
      end
      for (int k = 0; k < VecSize; k++) begin
        if (addr == VecCsrBase + k) begin
          m_vec[k] = wval[$bits(vec_store_t)-1:0];
        end
        if (addr == EntryCsrBase + k) begin
          m_entry[k] = entry_t'(wval[$bits(entry_t)-1:0]);
        end
      end
    end
    m_thresh = next_thresh;
  endfunction

`endif

// ==== tb/clic_tb.sv ====
// fixed seed random run; pc_in is picked from the model so the stack never overflows or underflows
`timescale 1ns/1ps

module clic_tb import clic_pkg::*; ();

  logic              clk;
  logic              reset;
  logic              csr_enable;
  csr_addr_t         csr_addr;
  reg_idx_t          rs1_zimm;
  word               rs1_data;
  csr_op_t           csr_op;
  i_mem_addr_t       pc_in;
  word               csr_out;
  i_mem_addr_t       int_addr;
  pc_interrupt_mux_t pc_interrupt_sel;
  level_t            level_out;
  logic              interrupt_out;

  int                mismatches;
  int                failures;
  int                n_take;
  int                n_nest;
  int                n_chain;
  int                n_ret;
  logic [31:0]       rng_state;

  `include "clic_model.svh"

  clic_top clic_top_i (
    .clk              (clk),
    .reset            (reset),
    .csr_enable       (csr_enable),
    .csr_addr         (csr_addr),
    .rs1_zimm         (rs1_zimm),
    .rs1_data         (rs1_data),
    .csr_op           (csr_op),
    .pc_in            (pc_in),
    .csr_out          (csr_out),
    .int_addr         (int_addr),
    .pc_interrupt_sel (pc_interrupt_sel),
    .level_out        (level_out),
    .interrupt_out    (interrupt_out)
  );

  always begin
    clk = 1'b0;
    #50;
    clk = 1'b1;
    #50;
  end

  function automatic logic [15:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[31:16];
  endfunction

  function automatic csr_op_t pick_op(int n);
    case (n)
      0:       return CSRRW;
      1:       return CSRRS;
      2:       return CSRRC;
      3:       return CSRRWI;
      4:       return CSRRSI;
      default: return CSRRCI;
    endcase
  endfunction

  task automatic check_word(string name, word got, word exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(string name, i_mem_addr_t got, i_mem_addr_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_sel(string name, pc_interrupt_mux_t got, pc_interrupt_mux_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_level(string name, level_t got, level_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // drive on the rising edge, check on the falling edge, then advance the model
  task automatic step(logic en, csr_addr_t addr, csr_op_t op, word data, reg_idx_t zimm,
                      i_mem_addr_t pc);
    @(posedge clk);
    csr_enable <= en;
    csr_addr   <= addr;
    csr_op     <= op;
    rs1_data   <= data;
    rs1_zimm   <= zimm;
    pc_in      <= pc;
    @(negedge clk);
    model_predict(addr, pc);
    check_word("csr_out", csr_out, m_exp_csr);
    check_addr("int_addr", int_addr, m_exp_addr);
    check_sel("pc_interrupt_sel", pc_interrupt_sel, m_exp_sel);
    check_level("level_out", level_out, m_exp_level);
    check_bit("interrupt_out", interrupt_out, m_exp_int);
    if (m_found && pc != RetMarker) begin
      n_take++;
      if (m_level > 0) begin
        n_nest++;
      end
    end else if (m_found) begin
      n_chain++;
    end else if (pc == RetMarker) begin
      n_ret++;
    end
    model_advance(en, addr, op, data, zimm, pc);
  endtask

  task automatic random_cycle();
    logic        en;
    csr_addr_t   addr;
    int          sel;
    logic        want_ret;
    i_mem_addr_t pc;
    en  = (lcg_next() % 3) != 0;
    sel = lcg_next() % 16;
    if (sel < 3) begin
      addr = MIntThreshAddr;
    end else if (sel < 8) begin
      addr = csr_addr_t'(VecCsrBase + lcg_next() % VecSize);
    end else if (sel < 14) begin
      addr = csr_addr_t'(EntryCsrBase + lcg_next() % VecSize);
    end else begin
      // gap between the vector and entry blocks
      addr = csr_addr_t'(VecCsrBase + VecSize + lcg_next() % 16);
    end
    // keep the stack within its depth
    model_find_best();
    want_ret = (lcg_next() % 4) == 0;
    if (m_found && m_level == PrioLevels) begin
      want_ret = 1'b1;
    end
    if (!m_found && m_level == 0) begin
      want_ret = 1'b0;
    end
    pc = want_ret ? RetMarker : (lcg_next() & 16'hfffe);
    step(en, addr, pick_op(lcg_next() % 6), {lcg_next(), lcg_next()},
         reg_idx_t'(lcg_next()), pc);
  endtask

  task automatic drain_stack();
    int cycles;
    cycles = 0;
    while (m_level != 0 && cycles < 200) begin
      step(1'b0, MIntThreshAddr, CSRRW, '0, '0, RetMarker);
      cycles++;
    end
    if (m_level != 0) begin
      failures++;
      $display("Timeout: stack still holds %0d entries after %0d returns", m_level, cycles);
    end
  endtask

  initial begin
    rng_state  = 32'd25;
    mismatches = 0;
    failures   = 0;
    n_take     = 0;
    n_nest     = 0;
    n_chain    = 0;
    n_ret      = 0;
    reset      = 1'b1;
    csr_enable = 1'b0;
    csr_addr   = '0;
    rs1_zimm   = '0;
    rs1_data   = '0;
    csr_op     = CSRRW;
    pc_in      = '0;
    model_reset();
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // every mapped register reads zero out of reset
    step(1'b0, MIntThreshAddr, CSRRW, '0, '0, 16'h0100);
    for (int k = 0; k < VecSize; k++) begin
      step(1'b0, csr_addr_t'(VecCsrBase + k), CSRRW, '0, '0, i_mem_addr_t'(16'h0200 + 4 * k));
      step(1'b0, csr_addr_t'(EntryCsrBase + k), CSRRW, '0, '0, i_mem_addr_t'(16'h0300 + 4 * k));
    end

    repeat (3000) random_cycle();
    drain_stack();

    $display("events: %0d takes, %0d nested, %0d tail chains, %0d returns",
             n_take, n_nest, n_chain, n_ret);
    if (n_take == 0 || n_nest == 0 || n_chain == 0 || n_ret == 0) begin
      failures++;
      $display("Random run missed at least one of take, nest, tail chain and return");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+tb
design/clic_pkg.sv
design/csr_bus_if.sv
design/csr_reg.sv
design/epc_stack.sv
design/prio_select.sv
design/n_clic.sv
design/clic_top.sv
tb/clic_tb.sv
